/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cache_controller
FILELIST  := filelist.f
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS      := src/cache_defs.svh
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
+incdir+src
src/cache_pkg.sv
src/way_lookup.sv
src/miss_fsm.sv
src/line_update.sv
src/cache_controller.sv
testbench/cache_controller_props.sv
testbench/tb_cache_controller.sv

/* src/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // cpu side, strobes only
  input  logic        cpu_req_valid,
  input  cpu_req_t    cpu_req,
  output logic        cpu_res_valid,
  output word_t       cpu_res_data,
  // tag/data array
  output logic        cache_en,
  output logic        cache_rw,      // 0 lookup, 1 commit
  output index_t      cache_index,
  input  logic        cache_ready,
  input  line_vec_t   cache_ways,
  output cache_line_t line_write,
  output way_sel_t    way_sel,
  output age_vec_t    ages,
  // memory, enable held until ready
  output logic        mem_en,
  output logic        mem_rw,
  output word_t       mem_addr,
  output block_t      mem_wdata,
  input  block_t      mem_rdata,
  input  logic        mem_ready
);

  cpu_req_t    req_q;
  lookup_t     lk;
  ctrl_state_t state;
  logic        accept;
  block_t      fill_block;

  assign cache_index = addr_index(req_q.addr);  // set of the held request

  way_lookup u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .accept        (accept),
    .cache_ready   (cache_ready),
    .cache_ways    (cache_ways),
    .req_q         (req_q),
    .lk            (lk)
  );

  miss_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req_valid (cpu_req_valid),
    .req_q         (req_q),
    .lk            (lk),
    .cache_ready   (cache_ready),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .state         (state),
    .accept        (accept),
    .cache_en      (cache_en),
    .cache_rw      (cache_rw),
    .mem_en        (mem_en),
    .mem_rw        (mem_rw),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .fill_block    (fill_block)
  );

  line_update u_update (
    .state         (state),
    .req_q         (req_q),
    .lk            (lk),
    .fill_block    (fill_block),
    .line_write    (line_write),
    .way_sel       (way_sel),
    .ages          (ages),
    .cpu_res_valid (cpu_res_valid),
    .cpu_res_data  (cpu_res_data)
  );

endmodule

/* src/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cpu word, also used as the word address
`define WORD_W 32

// word-in-block index, 16 words per block
`define OFFSET_W 4

// 128 sets
`define INDEX_W 7

// what is left of the address: 32 - 7 - 4
`define TAG_W 21

`define AGE_W 2      // lru age, 0 newest
`define NUM_WAYS 4   // ways per set

// 16 words of 32 bits
`define BLOCK_W 512

`endif

/* src/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`WORD_W-1:0]   word_t;     // data word or word address
  typedef logic [`TAG_W-1:0]    tag_t;
  typedef logic [`INDEX_W-1:0]  index_t;
  typedef logic [`OFFSET_W-1:0] offset_t;   // word within the block
  typedef logic [`AGE_W-1:0]    age_t;      // 0 newest .. 3 oldest
  typedef logic [`BLOCK_W-1:0]  block_t;
  typedef logic [`NUM_WAYS-1:0] way_sel_t;  // one-hot

  // same bit order as the array entries: valid on top, data at the bottom
  typedef struct packed {
    logic   valid;
    logic   dirty;
    age_t   age;
    tag_t   tag;
    block_t data;
  } cache_line_t;

  typedef cache_line_t [`NUM_WAYS-1:0] line_vec_t;
  typedef age_t [`NUM_WAYS-1:0] age_vec_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  rw;     // 1 = write
  } cpu_req_t;

  typedef struct packed {
    logic        hit;
    way_sel_t    hit_way;
    way_sel_t    victim_way;   // way at age 3
    logic        need_wb;      // victim valid and dirty on a miss
    cache_line_t line;         // hit line, or victim line on a miss
    age_t        prior_age;    // age of the hit way, 3 on a miss
    way_sel_t    way_valid;    // valid bits of all four candidates
    age_vec_t    way_age;      // current ages of all four candidates
  } lookup_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, CHECK, WRITEBACK, FILL, COMMIT} ctrl_state_t;

  // address = tag | index | offset
  function automatic tag_t addr_tag(input word_t a);
    return a[`WORD_W-1 -: `TAG_W];
  endfunction

  function automatic index_t addr_index(input word_t a);
    return a[`OFFSET_W +: `INDEX_W];
  endfunction

  function automatic offset_t addr_offset(input word_t a);
    return a[`OFFSET_W-1:0];
  endfunction

endpackage

/* src/line_update.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_update
  import cache_pkg::*;
(
  input  ctrl_state_t state,
  input  cpu_req_t    req_q,
  input  lookup_t     lk,
  input  block_t      fill_block,
  output cache_line_t line_write,
  output way_sel_t    way_sel,
  output age_vec_t    ages,
  output logic        cpu_res_valid,
  output word_t       cpu_res_data
);

  offset_t off;
  block_t  base_block;   // line contents before the cpu write
  block_t  merged;
  word_t   base_word;

  assign off = addr_offset(req_q.addr);

  // hit line as stored, or the freshly filled block on a miss
  assign base_block = lk.hit ? lk.line.data : fill_block;
  assign base_word  = base_block[off * `WORD_W +: `WORD_W];

  always_comb begin
    merged = base_block;
    if (req_q.rw) begin
      merged[off * `WORD_W +: `WORD_W] = req_q.wdata;  // write word lands at its offset
    end
  end

  always_comb begin
    line_write.valid = 1'b1;
    // write sets dirty, read miss is clean, read hit keeps the old bit
    line_write.dirty = req_q.rw | (lk.hit & lk.line.dirty);
    line_write.age   = '0;                      // written way becomes newest
    line_write.tag   = addr_tag(req_q.addr);    // equals the hit tag on a hit
    line_write.data  = merged;
  end

  assign way_sel = lk.hit ? lk.hit_way : lk.victim_way;

  // lru update over all four ways of the set
  always_comb begin
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (way_sel[w]) begin
        ages[w] = '0;
      end else if (lk.way_valid[w] && (lk.way_age[w] < lk.prior_age)) begin
        ages[w] = lk.way_age[w] + age_t'(1);  // younger than the touched way
      end else begin
        ages[w] = lk.way_age[w];              // older or invalid, untouched
      end
    end
  end

  // response goes out with the commit write
  assign cpu_res_valid = (state == COMMIT);
  assign cpu_res_data  = req_q.rw ? '0 : base_word;  // writes return zero

endmodule

/* src/miss_fsm.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module miss_fsm
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cpu_req_valid,
  input  cpu_req_t    req_q,
  input  lookup_t     lk,
  input  logic        cache_ready,
  input  logic        mem_ready,
  input  block_t      mem_rdata,
  output ctrl_state_t state,
  output logic        accept,
  output logic        cache_en,
  output logic        cache_rw,
  output logic        mem_en,
  output logic        mem_rw,
  output word_t       mem_addr,
  output block_t      mem_wdata,
  output block_t      fill_block
);

  ctrl_state_t next_state;
  logic        lookup_pend;  // lookup strobe, one cycle after accept
  logic        mem_gap;      // one idle cycle between two memory phases
  index_t      req_index;
  tag_t        req_tag;

  assign req_index = addr_index(req_q.addr);
  assign req_tag   = addr_tag(req_q.addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      lookup_pend <= 1'b0;
      mem_gap     <= 1'b0;
    end else begin
      state       <= next_state;
      lookup_pend <= accept && cpu_req_valid;
      mem_gap     <= mem_en && mem_ready;  // drop enable after each ready
    end
  end

  // block from memory, merged and written in COMMIT
  always_ff @(posedge clk) begin
    if (state == FILL && mem_en && mem_ready) begin
      fill_block <= mem_rdata;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (cpu_req_valid) next_state = LOOKUP;
      LOOKUP:    if (cache_ready) next_state = CHECK;  // candidates latched
      CHECK: begin
        if (lk.hit) begin
          next_state = COMMIT;
        end else if (lk.need_wb) begin
          next_state = WRITEBACK;
        end else begin
          next_state = FILL;
        end
      end
      WRITEBACK: if (mem_en && mem_ready) next_state = FILL;
      FILL:      if (mem_en && mem_ready) next_state = COMMIT;
      COMMIT:    next_state = IDLE;  // single cycle, no ready from the array
      default:   next_state = IDLE;
    endcase
  end

  assign accept = (state == IDLE);  // requests while busy are dropped

  // lookup strobe, or the commit write together with the response
  assign cache_en = lookup_pend || (state == COMMIT);
  assign cache_rw = (state == COMMIT);

  // enable held until ready, low for a cycle between write-back and fill
  assign mem_en = ((state == WRITEBACK) || (state == FILL)) && !mem_gap;
  assign mem_rw = (state == WRITEBACK);

  always_comb begin
    if (state == WRITEBACK) begin
      mem_addr = {lk.line.tag, req_index, {`OFFSET_W{1'b0}}};  // where the victim lives
    end else begin
      mem_addr = {req_tag, req_index, {`OFFSET_W{1'b0}}};      // aligned request block
    end
  end

  assign mem_wdata = (state == WRITEBACK) ? lk.line.data : '0;  // victim data

endmodule

/* src/way_lookup.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module way_lookup
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cpu_req_valid,
  input  cpu_req_t  cpu_req,
  input  logic      accept,       // fsm is idle
  input  logic      cache_ready,  // array answers a lookup
  input  line_vec_t cache_ways,
  output cpu_req_t  req_q,
  output lookup_t   lk
);

  localparam age_t oldest = age_t'(`NUM_WAYS - 1);

  line_vec_t ways_q;      // candidates of the indexed set
  way_sel_t  hit_way;
  way_sel_t  victim_way;
  tag_t      req_tag;

  assign req_tag = addr_tag(req_q.addr);

  // request held for the whole transaction, its index drives the array
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
    end else if (accept && cpu_req_valid) begin
      req_q <= cpu_req;
    end
  end

  // candidates only valid in the ready cycle, so keep a copy
  always_ff @(posedge clk) begin
    if (cache_ready) begin
      ways_q <= cache_ways;
    end
  end

  // tag compare against the registered candidates
  always_comb begin
    for (int w = 0; w < `NUM_WAYS; w++) begin
      hit_way[w]    = ways_q[w].valid && (ways_q[w].tag == req_tag);
      victim_way[w] = (ways_q[w].age == oldest);  // lru way
    end
  end

  always_comb begin
    lk            = '0;
    lk.hit        = |hit_way;
    lk.hit_way    = hit_way;
    lk.victim_way = victim_way;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      lk.way_valid[w] = ways_q[w].valid;
      lk.way_age[w]   = ways_q[w].age;
      // hit way wins; otherwise the victim is the line we replace
      if (lk.hit ? hit_way[w] : victim_way[w]) begin
        lk.line = ways_q[w];
      end
    end

    // a miss brings in a line as if it had been the oldest
    // so every younger valid way ages by one
    lk.prior_age = lk.hit ? lk.line.age : oldest;

    lk.need_wb = !lk.hit && lk.line.valid && lk.line.dirty;  // dirty victim
  end

endmodule

/* testbench/cache_controller_props.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_controller_props
  import cache_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     cpu_res_valid,
  input logic     cache_en,
  input logic     cache_rw,
  input logic     cache_ready,
  input way_sel_t way_sel,
  input logic     mem_en,
  input logic     mem_rw,
  input word_t    mem_addr,
  input logic     mem_ready
);

  int fail_count = 0;  // failures so far, watched by the testbench

  // outputs quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !cache_en && !mem_en && !cpu_res_valid)
    else begin fail_count++; $error("outputs active during reset"); end

  // enable, address and direction held until ready
  a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_en && !mem_ready |=> mem_en && $stable(mem_addr) && $stable(mem_rw))
    else begin fail_count++; $error("memory request dropped before ready"); end

  // one cycle of tag check, then either the commit or the first memory phase
  a_check_next: assert property (@(posedge clk) disable iff (!rst_n)
    cache_ready |-> ##2 (cpu_res_valid != mem_en))
    else begin fail_count++; $error("no commit or memory phase after tag check"); end

  // response always travels with the commit write
  a_res_commit: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_res_valid |-> cache_en && cache_rw)
    else begin fail_count++; $error("response without commit"); end

  a_commit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    cache_en && cache_rw |-> $onehot(way_sel))
    else begin fail_count++; $error("commit way select not one-hot"); end

  a_lookup_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    cache_en && !cache_rw |=> !cache_en)  // single cycle strobe
    else begin fail_count++; $error("lookup strobe longer than one cycle"); end

endmodule

bind cache_controller cache_controller_props u_props (.*);

/* testbench/tb_cache_controller.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache_controller
  import cache_pkg::*;
();

  localparam int TIMEOUT = 60;

  logic clk = 1'b0, rst_n;
  logic cpu_req_valid, cpu_res_valid, cache_en, cache_rw, cache_ready;
  logic mem_en, mem_rw, mem_ready;
  cpu_req_t cpu_req;
  word_t cpu_res_data, mem_addr;
  index_t cache_index;
  line_vec_t cache_ways, set_ways;  // set_ways is the set the array holds
  cache_line_t line_write;
  way_sel_t way_sel;
  age_vec_t ages;
  block_t mem_wdata, mem_rdata;
  logic [31:0] rng = 32'h1cdd6ad7;

  cache_controller dut0 (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] rand32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // memory contents, every word depends on the whole block address
  function automatic block_t mem_block(input word_t a);
    block_t b;
    for (int i = 0; i < 16; i++) b[i*32 +: 32] = (a * 32'h9e3779b1) ^ {i[7:0], a[31:8]};
    return b;
  endfunction

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // a failed concurrent assertion ends the run at once
  always @(negedge clk) begin
    if (dut0.u_props.fail_count != 0) stop_with("a concurrent assertion failed");
  end

  task automatic mem_reply(input word_t a, input logic rw);
    repeat (int'(rand32() % 32'd3)) @(posedge clk);
    @(posedge clk);
    mem_ready <= 1'b1;
    mem_rdata <= rw ? '0 : mem_block(a);
    @(posedge clk);
    mem_ready <= 1'b0;
  endtask

  // kind: 0/1 read/write hit, 2/3 clean miss, 4/5 dirty miss
  task automatic run_case(input int kind);
    cpu_req_t req;
    int hw, vw, sel, rot, n, nph, lookups;
    bit hit, done;
    tag_t rtag;
    index_t ridx;
    offset_t roff;
    age_t prior;
    age_vec_t exp_ages;
    block_t base, exp_data;
    word_t exp_res;
    logic exp_dirty;
    time t_ready;
    logic ph_rw [2];
    word_t ph_addr [2];
    block_t ph_wdata [2];
    hit = kind < 2;
    req.rw = kind[0];
    req.addr = rand32();
    req.wdata = rand32();
    rtag = req.addr[31:11];
    ridx = req.addr[10:4];
    roff = req.addr[3:0];
    rot = int'(rand32() % 32'd4);
    for (int w = 0; w < 4; w++) begin
      set_ways[w].valid = rng[0];
      set_ways[w].dirty = rand32() > 32'h80000000;
      set_ways[w].age = age_t'((w + rot) % 4);  // rotation keeps a permutation
      set_ways[w].tag = rtag ^ tag_t'(w + 1);   // never the request tag
      for (int i = 0; i < 16; i++) set_ways[w].data[i*32 +: 32] = rand32();
    end
    vw = (7 - rot) % 4;  // way at age 3
    hw = int'(rand32() % 32'd4);
    if (hit) begin
      set_ways[hw].tag = rtag;
      set_ways[hw].valid = 1'b1;
    end else begin
      set_ways[vw].dirty = kind >= 4;
      if (kind >= 4) set_ways[vw].valid = 1'b1;
    end
    sel = hit ? hw : vw;
    prior = hit ? set_ways[hw].age : 2'd3;
    base = hit ? set_ways[hw].data : mem_block({rtag, ridx, 4'b0});
    exp_data = base;
    if (req.rw) exp_data[roff*32 +: 32] = req.wdata;
    exp_res = req.rw ? '0 : base[roff*32 +: 32];
    for (int w = 0; w < 4; w++) begin
      if (w == sel) exp_ages[w] = '0;
      else if (set_ways[w].valid && set_ways[w].age < prior) exp_ages[w] = set_ways[w].age + 2'd1;
      else exp_ages[w] = set_ways[w].age;
    end
    if (req.rw) exp_dirty = 1'b1;                   // any write leaves the line dirty
    else if (hit) exp_dirty = set_ways[hw].dirty;  // read hit keeps it
    else exp_dirty = 1'b0;                          // fresh copy of memory

    @(posedge clk);
    cpu_req_valid <= 1'b1;
    cpu_req <= req;
    @(posedge clk);
    cpu_req_valid <= 1'b0;
    done = 0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = cache_en && !cache_rw;
    end
    if (!done) stop_with("the controller never issued a lookup");
    assert (cache_index == ridx) else stop_with($sformatf("ERR %0t: lookup index", $time));
    lookups = 0;
    if (hit) begin  // strobe while busy, must be ignored
      @(posedge clk) cpu_req_valid <= 1'b1;
      @(posedge clk) cpu_req_valid <= 1'b0;
      @(negedge clk) if (cache_en && !cache_rw) lookups++;
    end
    repeat (int'(rand32() % 32'd3)) @(posedge clk);
    @(posedge clk);
    cache_ready <= 1'b1;
    cache_ways <= set_ways;
    @(negedge clk) t_ready = $time;
    @(posedge clk) cache_ready <= 1'b0;

    nph = 0;
    done = 0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(negedge clk);
      if (cache_en && !cache_rw) lookups++;
      if (mem_en) begin
        if (nph >= 2) stop_with("more memory transactions than a miss needs");
        ph_rw[nph] = mem_rw;
        ph_addr[nph] = mem_addr;
        ph_wdata[nph] = mem_wdata;
        nph++;
        mem_reply(mem_addr, mem_rw);
      end else if (cpu_res_valid) begin
        done = 1;
      end
    end
    if (!done) stop_with("no response from the controller");

    assert (lookups == 0) else stop_with($sformatf("ERR %0t: extra lookup", $time));
    if (hit) assert ($time - t_ready == 16)
      else stop_with($sformatf("ERR %0t: hit latency", $time));
    assert (nph == (hit ? 0 : (kind >= 4 ? 2 : 1)))
      else stop_with($sformatf("ERR %0t: memory transaction count %0d", $time, nph));
    if (kind >= 4) assert (ph_rw[0] && ph_addr[0] == {set_ways[vw].tag, ridx, 4'b0}
                           && ph_wdata[0] == set_ways[vw].data)
      else stop_with($sformatf("ERR %0t: write-back of the victim", $time));
    if (!hit) assert (!ph_rw[nph-1] && ph_addr[nph-1] == {rtag, ridx, 4'b0})
      else stop_with($sformatf("ERR %0t: fill read", $time));
    assert (way_sel == way_sel_t'(1 << sel))
      else stop_with($sformatf("ERR %0t: way_sel %b", $time, way_sel));
    assert (line_write.data == exp_data && line_write.tag == rtag && line_write.valid
            && line_write.dirty == exp_dirty && line_write.age == '0)
      else stop_with($sformatf("ERR %0t: line written at commit", $time));
    assert (ages == exp_ages)
      else stop_with($sformatf("ERR %0t: ages %h expected %h", $time, ages, exp_ages));
    assert (cpu_res_data == exp_res)
      else stop_with($sformatf("ERR %0t: response %h expected %h", $time, cpu_res_data, exp_res));
  endtask

  initial begin
    rst_n = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    cache_ready = 1'b0;
    cache_ways = '0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!cache_en && !mem_en && !cpu_res_valid)
      else stop_with($sformatf("ERR %0t: outputs active after reset", $time));
    for (int rep = 0; rep < 4; rep++) begin
      for (int k = 0; k < 6; k++) run_case(k);
    end
    repeat (2) @(posedge clk);
    if (dut0.u_props.fail_count != 0) begin
      $display("concurrent assertions failed during the run");
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule
